/* common/glb_macros.svh */
//----------------------------------------------------------------------
// Tile widths; GLB_ADDR_WIDTH minus GLB_BANK_ADDR_WIDTH bits pick the bank
//----------------------------------------------------------------------
`ifndef GLB_MACROS_SVH
`define GLB_MACROS_SVH

// Stream and bank word width
`define GLB_DATA_WIDTH 16

// Global word address, top bit selects the bank
`define GLB_ADDR_WIDTH 10

// Word address inside one bank
`define GLB_BANK_ADDR_WIDTH 9

`define GLB_NUM_BANKS 2

// APB byte offset width
`define GLB_APB_ADDR_WIDTH 8

`endif

/* common/glb_pkg.sv */
//----------------------------------------------------------------------
// DMA header layouts and APB register offsets; headers are one 32-bit word
//----------------------------------------------------------------------
`include "glb_macros.svh"

package glb_pkg;

    typedef logic [11:0] word_cnt_t;
    typedef logic [3:0]  stride_t;

    // Store view, start address in the low bits
    typedef struct packed {
        logic [9:0]                 reserved;
        word_cnt_t                  num_words;
        logic [`GLB_ADDR_WIDTH-1:0] start_addr;
    } dma_st_header_t;

    // Load view adds the address stride
    typedef struct packed {
        logic [5:0]                 reserved;
        stride_t                    stride;
        word_cnt_t                  num_words;
        logic [`GLB_ADDR_WIDTH-1:0] start_addr;
    } dma_ld_header_t;

    // Same APB word, two decodings
    typedef union packed {
        dma_st_header_t st;
        dma_ld_header_t ld;
    } dma_header_u;

    localparam logic [`GLB_APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
    localparam logic [`GLB_APB_ADDR_WIDTH-1:0] REG_ST_HDR = 8'h04;
    localparam logic [`GLB_APB_ADDR_WIDTH-1:0] REG_LD_HDR = 8'h08;
    localparam logic [`GLB_APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h0C;

endpackage

/* src/glb_cfg_regs.sv */
//----------------------------------------------------------------------
// APB slave with no wait states; start bits act only during the access phase
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_cfg_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`GLB_APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output glb_pkg::dma_st_header_t         st_header,
    output glb_pkg::dma_ld_header_t         ld_header,
    output logic                            st_start,
    output logic                            ld_start,
    input  logic                            st_done,
    input  logic                            ld_done,
    output logic                            strm_f2g_interrupt_pulse,
    output logic                            strm_g2f_interrupt_pulse
);
    import glb_pkg::*;

    logic        access;
    logic        addr_hit;
    logic        wr_ctrl;
    logic        wr_st_hdr;
    logic        wr_ld_hdr;
    logic        wr_status;
    logic        st_busy;
    logic        ld_busy;
    logic        st_done_sticky;
    logic        ld_done_sticky;
    dma_header_u hdr_wdata;

    // Access phase of a transfer
    assign access   = psel && penable;
    assign addr_hit = paddr inside {REG_CTRL, REG_ST_HDR, REG_LD_HDR, REG_STATUS};
    assign pready   = 1'b1;
    assign pslverr  = access && !addr_hit;

    assign wr_ctrl   = access && pwrite && (paddr == REG_CTRL);
    assign wr_st_hdr = access && pwrite && (paddr == REG_ST_HDR);
    assign wr_ld_hdr = access && pwrite && (paddr == REG_LD_HDR);
    assign wr_status = access && pwrite && (paddr == REG_STATUS);

    // Write word seen as either header
    assign hdr_wdata = pwdata;

    // DMAs latch on the access-phase edge
    assign st_start = wr_ctrl && pwdata[0];
    assign ld_start = wr_ctrl && pwdata[1];

    always_comb begin
        case (paddr)
            REG_ST_HDR: prdata = st_header;
            REG_LD_HDR: prdata = ld_header;
            REG_STATUS: prdata = {28'd0, ld_done_sticky, st_done_sticky, ld_busy, st_busy};
            // Control reads as zero
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_header                <= '0;
            ld_header                <= '0;
            st_busy                  <= 1'b0;
            ld_busy                  <= 1'b0;
            st_done_sticky           <= 1'b0;
            ld_done_sticky           <= 1'b0;
            strm_f2g_interrupt_pulse <= 1'b0;
            strm_g2f_interrupt_pulse <= 1'b0;
        end else begin
            if (wr_st_hdr) st_header <= hdr_wdata.st;
            if (wr_ld_hdr) ld_header <= hdr_wdata.ld;

            // Busy from start until done
            if (st_start) st_busy <= 1'b1;
            else if (st_done) st_busy <= 1'b0;
            if (ld_start) ld_busy <= 1'b1;
            else if (ld_done) ld_busy <= 1'b0;

            // Done sets the sticky bit even during a clear write
            if (st_done) st_done_sticky <= 1'b1;
            else if (wr_status && pwdata[2]) st_done_sticky <= 1'b0;
            if (ld_done) ld_done_sticky <= 1'b1;
            else if (wr_status && pwdata[3]) ld_done_sticky <= 1'b0;

            // Interrupt lines up with the sticky bit
            strm_f2g_interrupt_pulse <= st_done;
            strm_g2f_interrupt_pulse <= ld_done;
        end
    end

    // A DMA reports done only while its busy bit is set
    a_st_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
        st_done |-> st_busy);
    a_ld_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
        ld_done |-> ld_busy);

endmodule

/* glb_bank/glb_bank.sv */
//----------------------------------------------------------------------
// Single-port SRAM, read data one cycle after en; contents start undefined
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_bank (
    input  logic                            clk,
    input  logic                            en,
    input  logic                            wr_en,
    input  logic [`GLB_BANK_ADDR_WIDTH-1:0] addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      wr_data,
    output logic [`GLB_DATA_WIDTH-1:0]      rd_data
);

    localparam int DEPTH = 2 ** `GLB_BANK_ADDR_WIDTH;

    logic [`GLB_DATA_WIDTH-1:0] mem [DEPTH];

    // Write or registered read, never both
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end else begin
                rd_data <= mem[addr];
            end
        end
    end

endmodule

/* glb_dma/glb_store_dma.sv */
//----------------------------------------------------------------------
// Store DMA, no back-pressure; words arriving while idle are dropped
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_store_dma (
    input  logic                        clk,
    input  logic                        arst_n,
    input  glb_pkg::dma_st_header_t     st_header,
    input  logic                        st_start,
    input  logic [`GLB_DATA_WIDTH-1:0]  stream_data_f2g,
    input  logic                        stream_data_valid_f2g,
    output logic                        wr_en,
    output logic [`GLB_ADDR_WIDTH-1:0]  wr_addr,
    output logic [`GLB_DATA_WIDTH-1:0]  wr_data,
    output logic                        st_done
);
    import glb_pkg::*;

    logic                       busy;
    logic                       accept;
    logic [`GLB_ADDR_WIDTH-1:0] cur_addr;
    word_cnt_t                  remaining;

    // Take a word only while words are still owed
    assign accept = busy && stream_data_valid_f2g && (remaining != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            remaining <= '0;
            wr_en     <= 1'b0;
            st_done   <= 1'b0;
        end else begin
            wr_en   <= accept;
            st_done <= 1'b0;
            if (st_start && !busy) begin
                remaining <= st_header.num_words;
                // Zero count finishes at once
                if (st_header.num_words == '0) st_done <= 1'b1;
                else busy <= 1'b1;
            end else if (accept) begin
                remaining <= remaining - 1'b1;
            end else if (busy && remaining == '0) begin
                // Last write went out last cycle
                busy    <= 1'b0;
                st_done <= 1'b1;
            end
        end
    end

    // Address wraps within the tile
    always_ff @(posedge clk) begin
        if (st_start && !busy) begin
            cur_addr <= st_header.start_addr;
        end else if (accept) begin
            cur_addr <= cur_addr + 1'b1;
            wr_addr  <= cur_addr;
            wr_data  <= stream_data_f2g;
        end
    end

    a_wr_only_busy: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> busy);

endmodule

/* glb_dma/glb_load_dma.sv */
//----------------------------------------------------------------------
// Load DMA, strided reads out as a stream two cycles after each grant
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_load_dma (
    input  logic                        clk,
    input  logic                        arst_n,
    input  glb_pkg::dma_ld_header_t     ld_header,
    input  logic                        ld_start,
    output logic                        rd_req,
    output logic [`GLB_ADDR_WIDTH-1:0]  rd_addr,
    input  logic                        rd_gnt,
    input  logic                        rd_valid,
    input  logic [`GLB_DATA_WIDTH-1:0]  rd_data,
    output logic [`GLB_DATA_WIDTH-1:0]  stream_data_g2f,
    output logic                        stream_data_valid_g2f,
    output logic                        ld_done
);
    import glb_pkg::*;

    logic      busy;
    word_cnt_t issue_left;
    word_cnt_t ret_left;
    stride_t   stride_q;

    // Request until every read is issued
    assign rd_req = busy && (issue_left != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy                  <= 1'b0;
            issue_left            <= '0;
            ret_left              <= '0;
            ld_done               <= 1'b0;
            stream_data_valid_g2f <= 1'b0;
        end else begin
            ld_done               <= 1'b0;
            stream_data_valid_g2f <= rd_valid;
            if (ld_start && !busy) begin
                issue_left <= ld_header.num_words;
                ret_left   <= ld_header.num_words;
                if (ld_header.num_words == '0) ld_done <= 1'b1;
                else busy <= 1'b1;
            end else if (busy) begin
                // Issued and returned counts move independently
                if (rd_gnt) issue_left <= issue_left - 1'b1;
                if (rd_valid) ret_left <= ret_left - 1'b1;
                // All returned, last word on the stream now
                if (ret_left == '0) begin
                    busy    <= 1'b0;
                    ld_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_start && !busy) begin
            rd_addr  <= ld_header.start_addr;
            stride_q <= ld_header.stride;
        end else if (rd_gnt) begin
            // Wraps in the 10-bit space, may cross banks
            rd_addr <= rd_addr + `GLB_ADDR_WIDTH'(stride_q);
        end
        if (rd_valid) stream_data_g2f <= rd_data;
    end

    // Refused request held for retry
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        rd_req && !rd_gnt |=> rd_req && $stable(rd_addr));

endmodule

/* src/glb_bank_switch.sv */
//----------------------------------------------------------------------
// Store wins bank conflicts; refused reads retry the next cycle
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_bank_switch (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            wr_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]      wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]      wr_data,
    input  logic                            rd_req,
    input  logic [`GLB_ADDR_WIDTH-1:0]      rd_addr,
    output logic                            rd_gnt,
    output logic                            rd_valid,
    output logic [`GLB_DATA_WIDTH-1:0]      rd_data,
    output logic                            bank_en      [`GLB_NUM_BANKS],
    output logic                            bank_wr_en   [`GLB_NUM_BANKS],
    output logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr    [`GLB_NUM_BANKS],
    output logic [`GLB_DATA_WIDTH-1:0]      bank_wr_data [`GLB_NUM_BANKS],
    input  logic [`GLB_DATA_WIDTH-1:0]      bank_rd_data [`GLB_NUM_BANKS]
);

    localparam int SEL_W = `GLB_ADDR_WIDTH - `GLB_BANK_ADDR_WIDTH;

    logic [SEL_W-1:0]          wr_bank;
    logic [SEL_W-1:0]          rd_bank;
    logic [SEL_W-1:0]          rd_bank_q;
    logic [`GLB_NUM_BANKS-1:0] wr_sel;
    logic [`GLB_NUM_BANKS-1:0] rd_sel;

    // Bank from the top address bits
    assign wr_bank = wr_addr[`GLB_ADDR_WIDTH-1 -: SEL_W];
    assign rd_bank = rd_addr[`GLB_ADDR_WIDTH-1 -: SEL_W];
    assign rd_gnt  = rd_req && !(wr_en && (wr_bank == rd_bank));

    for (genvar b = 0; b < `GLB_NUM_BANKS; b++) begin : g_route
        assign wr_sel[b]       = wr_en && (wr_bank == SEL_W'(b));
        assign rd_sel[b]       = rd_gnt && (rd_bank == SEL_W'(b));
        assign bank_en[b]      = wr_sel[b] || rd_sel[b];
        assign bank_wr_en[b]   = wr_sel[b];
        assign bank_addr[b]    = wr_sel[b] ? wr_addr[`GLB_BANK_ADDR_WIDTH-1:0]
                                           : rd_addr[`GLB_BANK_ADDR_WIDTH-1:0];
        assign bank_wr_data[b] = wr_data;
    end

    // Bank answers one cycle after the grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) rd_valid <= 1'b0;
        else rd_valid <= rd_gnt;
    end

    always_ff @(posedge clk) begin
        if (rd_gnt) rd_bank_q <= rd_bank;
    end

    assign rd_data = bank_rd_data[rd_bank_q];

    // One bank per source, never both on one bank
    a_bank_sel: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(wr_sel) && $onehot0(rd_sel) && ((wr_sel & rd_sel) == '0));

endmodule

/* src/glb_tile.sv */
//----------------------------------------------------------------------
// Buffer tile top, APB for configuration only; streams have no ready
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module glb_tile (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`GLB_APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic [`GLB_DATA_WIDTH-1:0]      stream_data_f2g,
    input  logic                            stream_data_valid_f2g,
    output logic [`GLB_DATA_WIDTH-1:0]      stream_data_g2f,
    output logic                            stream_data_valid_g2f,
    output logic                            strm_f2g_interrupt_pulse,
    output logic                            strm_g2f_interrupt_pulse
);
    import glb_pkg::*;

    dma_st_header_t                 st_header;
    dma_ld_header_t                 ld_header;
    logic                           st_start, ld_start, st_done, ld_done;
    // Store DMA to switch
    logic                           wr_en;
    logic [`GLB_ADDR_WIDTH-1:0]     wr_addr;
    logic [`GLB_DATA_WIDTH-1:0]     wr_data;
    // Load DMA to and from switch
    logic                           rd_req, rd_gnt, rd_valid;
    logic [`GLB_ADDR_WIDTH-1:0]     rd_addr;
    logic [`GLB_DATA_WIDTH-1:0]     rd_data;
    // Switch to banks
    logic                           bank_en      [`GLB_NUM_BANKS];
    logic                           bank_wr_en   [`GLB_NUM_BANKS];
    logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr   [`GLB_NUM_BANKS];
    logic [`GLB_DATA_WIDTH-1:0]     bank_wr_data [`GLB_NUM_BANKS];
    logic [`GLB_DATA_WIDTH-1:0]     bank_rd_data [`GLB_NUM_BANKS];

    glb_cfg_regs glb_cfg_regs (.*);

    glb_store_dma glb_store_dma (.*);

    glb_load_dma glb_load_dma (.*);

    glb_bank_switch glb_bank_switch (.*);

    for (genvar i = 0; i < `GLB_NUM_BANKS; i++) begin : g_bank
        glb_bank glb_bank (
            .clk     (clk),
            .en      (bank_en[i]),
            .wr_en   (bank_wr_en[i]),
            .addr    (bank_addr[i]),
            .wr_data (bank_wr_data[i]),
            .rd_data (bank_rd_data[i])
        );
    end

endmodule

/* verification/tb_glb_tile.sv */
//----------------------------------------------------------------------
// Run from the project root; the first store case must fill the memory
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "glb_macros.svh"

module tb_glb_tile;

    localparam int ADDR_SPACE = 2 ** `GLB_ADDR_WIDTH;

    logic                           clk, arst_n;
    logic                           psel, penable, pwrite, pready, pslverr;
    logic [`GLB_APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                    pwdata, prdata;
    logic [`GLB_DATA_WIDTH-1:0]     stream_data_f2g, stream_data_g2f;
    logic                           stream_data_valid_f2g, stream_data_valid_g2f;
    logic                           strm_f2g_interrupt_pulse, strm_g2f_interrupt_pulse;

    // Reference memory and word queues
    logic [`GLB_DATA_WIDTH-1:0] model [ADDR_SPACE];
    logic [`GLB_DATA_WIDTH-1:0] ld_words[$];
    logic [`GLB_DATA_WIDTH-1:0] exp_words[$];
    logic [`GLB_DATA_WIDTH-1:0] st_words[$];
    // Cases as read from the file
    string                      c_name[$];
    int                         c_a[$], c_b[$], c_n[$], c_s[$];
    logic [31:0]                rng;
    int                         st_irqs, ld_irqs, errors, fails, checks, cycles, limit;

    glb_tile i_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (stream_data_valid_g2f) ld_words.push_back(stream_data_g2f);
        if (strm_f2g_interrupt_pulse) st_irqs++;
        if (strm_g2f_interrupt_pulse) ld_irqs++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic apb(input logic wr, input logic [`GLB_APB_ADDR_WIDTH-1:0] addr,
                       input logic [31:0] wdata, output logic [31:0] rdata);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        step();
        penable = 1'b1;
        #1;
        rdata = prdata;
        // Only the four registers are mapped
        check("pslverr", pslverr, !(addr inside {8'h00, 8'h04, 8'h08, 8'h0C}));
        check("pready", pready, 1);
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [`GLB_APB_ADDR_WIDTH-1:0] addr, input logic [31:0] d);
        logic [31:0] unused;
        apb(1'b1, addr, d, unused);
    endtask

    task automatic read_expect(input logic [`GLB_APB_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] exp, input string what);
        logic [31:0] rd;
        apb(1'b0, addr, 32'd0, rd);
        check(what, rd, exp);
    endtask

    task automatic wait_irq(input bit load, input int target, input int max_cycles);
        int waited;
        waited = 0;
        while ((load ? ld_irqs : st_irqs) < target && waited < max_cycles) begin
            step();
            waited++;
        end
        if ((load ? ld_irqs : st_irqs) < target) begin
            fails++;
            $display("%s interrupt did not arrive within %0d cycles",
                     load ? "load" : "store", max_cycles);
        end
    endtask

    // Random gaps, about three valid words in four
    task automatic send_stream(input int n);
        logic [31:0] r;
        st_words.delete();
        while (st_words.size() < n) begin
            r = next_rand();
            stream_data_valid_f2g = (r[1:0] != 2'b00);
            stream_data_f2g       = r[31:16];
            if (r[1:0] != 2'b00) st_words.push_back(r[31:16]);
            step();
        end
        stream_data_valid_f2g = 1'b0;
    endtask

    task automatic commit_store(input int addr);
        for (int i = 0; i < st_words.size(); i++) model[(addr + i) % ADDR_SPACE] = st_words[i];
    endtask

    task automatic predict_load(input int addr, input int n, input int s);
        exp_words.delete();
        for (int i = 0; i < n; i++) exp_words.push_back(model[(addr + i * s) % ADDR_SPACE]);
    endtask

    task automatic compare_load();
        if (ld_words.size() != exp_words.size()) begin
            fails++;
            $display("load returned %0d stream words, expected %0d",
                     ld_words.size(), exp_words.size());
        end
        for (int i = 0; i < exp_words.size() && i < ld_words.size(); i++)
            check($sformatf("load word %0d", i), ld_words[i], exp_words[i]);
    endtask

    // Status read, then write-one-to-clear both done bits
    task automatic status_clear(input logic [31:0] exp);
        read_expect(8'h0C, exp, "status after done");
        apb_write(8'h0C, 32'hC);
        read_expect(8'h0C, 32'h0, "status after clear");
    endtask

    task automatic run_regs(input int bad);
        logic [31:0] w1, w2;
        logic [31:0] unused;
        w1 = next_rand();
        w2 = next_rand();
        apb_write(8'h04, w1);
        apb_write(8'h08, w2);
        read_expect(8'h04, w1, "store header");
        read_expect(8'h08, w2, "load header");
        read_expect(8'h00, 32'h0, "control");
        apb_write(bad[7:0], ~w1);
        apb(1'b0, bad[7:0], 32'd0, unused);
        read_expect(8'h04, w1, "store header after unmapped write");
        read_expect(8'h08, w2, "load header after unmapped write");
        read_expect(8'h0C, 32'h0, "status after unmapped write");
    endtask

    task automatic run_load(input int addr, input int n, input int s);
        int base;
        base = ld_irqs;
        predict_load(addr, n, s);
        apb_write(8'h08, {6'd0, 4'(s), 12'(n), 10'(addr)});
        ld_words.delete();
        apb_write(8'h00, 32'h2);
        wait_irq(1'b1, base + 1, 4 * n + 20);
        repeat (3) step();
        check("load interrupt count", ld_irqs - base, 1);
        compare_load();
        status_clear(32'h8);
    endtask

    // Store, then read the region back with unit stride
    task automatic run_store(input int addr, input int n);
        int base;
        base = st_irqs;
        apb_write(8'h04, {10'd0, 12'(n), 10'(addr)});
        apb_write(8'h00, 32'h1);
        send_stream(n);
        wait_irq(1'b0, base + 1, 20);
        repeat (3) step();
        check("store interrupt count", st_irqs - base, 1);
        commit_store(addr);
        status_clear(32'h4);
        run_load(addr, n, 1);
    endtask

    // Regions do not overlap, so the load sees memory before the store
    task automatic run_concurrent(input int a, input int b, input int n, input int s);
        int st_base, ld_base;
        st_base = st_irqs;
        ld_base = ld_irqs;
        apb_write(8'h04, {10'd0, 12'(n), 10'(a)});
        apb_write(8'h08, {6'd0, 4'(s), 12'(n), 10'(b)});
        predict_load(b, n, s);
        ld_words.delete();
        apb_write(8'h00, 32'h3);
        send_stream(n);
        wait_irq(1'b0, st_base + 1, 20);
        wait_irq(1'b1, ld_base + 1, 4 * n + 20);
        repeat (3) step();
        check("store interrupt count", st_irqs - st_base, 1);
        check("load interrupt count", ld_irqs - ld_base, 1);
        compare_load();
        commit_store(a);
        status_clear(32'hC);
        run_load(a, n, 1);
    endtask

    task automatic run_zerolen(input int a, input int n);
        int st_base, ld_base;
        st_base = st_irqs;
        ld_base = ld_irqs;
        apb_write(8'h04, {10'd0, 12'd0, 10'(a)});
        apb_write(8'h08, {6'd0, 4'd1, 12'd0, 10'(a)});
        apb_write(8'h00, 32'h1);
        wait_irq(1'b0, st_base + 1, 8);
        apb_write(8'h00, 32'h2);
        wait_irq(1'b1, ld_base + 1, 8);
        repeat (3) step();
        check("store interrupt count", st_irqs - st_base, 1);
        check("load interrupt count", ld_irqs - ld_base, 1);
        // Busy bits low, clear one done bit at a time
        read_expect(8'h0C, 32'hC, "status after zero-length DMAs");
        apb_write(8'h0C, 32'h4);
        read_expect(8'h0C, 32'h8, "status after clearing store done");
        apb_write(8'h0C, 32'h8);
        read_expect(8'h0C, 32'h0, "status after clearing load done");
        // Idle store DMA drops these words
        send_stream(n);
        repeat (3) step();
        run_load(a, n, 1);
    endtask

    task automatic read_cases();
        int          fd, a, b, n, s;
        string       line;
        logic [95:0] op;
        fd = $fopen("verification/glb_cases.txt", "r");
        if (fd == 0) begin
            fails++;
            $display("could not open verification/glb_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#"
                    && $sscanf(line, "%s %h %h %d %d", op, a, b, n, s) == 5) begin
                c_name.push_back(string'(op));
                c_a.push_back(a);
                c_b.push_back(b);
                c_n.push_back(n);
                c_s.push_back(s);
                limit += 4 * n + 200;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int err_before, fail_before, failed_tests;
        rng                   = 32'h91ac;
        limit                 = 100;
        failed_tests          = 0;
        arst_n                = 1'b0;
        psel                  = 1'b0;
        penable               = 1'b0;
        pwrite                = 1'b0;
        paddr                 = '0;
        pwdata                = '0;
        stream_data_f2g       = '0;
        stream_data_valid_f2g = 1'b0;
        read_cases();
        if (c_name.size() == 0) begin
            fails++;
            $display("no test cases were read");
        end
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        step();
        for (int t = 0; t < c_name.size(); t++) begin
            err_before  = errors;
            fail_before = fails;
            if (c_name[t] == "regs") run_regs(c_a[t]);
            else if (c_name[t] == "store") run_store(c_a[t], c_n[t]);
            else if (c_name[t] == "load") run_load(c_a[t], c_n[t], c_s[t]);
            else if (c_name[t] == "concurrent") run_concurrent(c_a[t], c_b[t], c_n[t], c_s[t]);
            else if (c_name[t] == "zerolen") run_zerolen(c_a[t], c_n[t]);
            else begin
                fails++;
                $display("unknown operation %s in case %0d", c_name[t], t);
            end
            if (errors != err_before || fails != fail_before) failed_tests++;
            $display("test %0d %s a=%0h b=%0h n=%0d s=%0d: %s", t, c_name[t], c_a[t], c_b[t],
                     c_n[t], c_s[t],
                     (errors == err_before && fails == fail_before) ? "ok" : "failed");
        end
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, other failures %0d",
                 c_name.size(), failed_tests, checks, errors, fails);
        if (failed_tests == 0 && errors == 0 && fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verification/glb_cases.txt */
# op  addr_a(hex)  addr_b(hex)  words  stride
# regs: addr_a is an unmapped APB offset; concurrent: store at addr_a, load from addr_b
regs       10   000  0     0
regs       fc   000  0     0
store      000  000  1024  1
store      3f8  000  16    1
store      1f8  000  16    1
load       000  000  64    1
load       020  000  40    3
load       1f0  000  32    7
load       3f0  000  24    5
load       100  000  100   15
load       2a0  000  50    2
concurrent 010  100  32    1
concurrent 1c0  180  16    1
concurrent 050  250  48    2
concurrent 300  000  20    4
zerolen    080  000  8     0
zerolen    200  000  4     0
store      120  000  40    1
load       110  000  30    9
regs       02   000  0     0

/* list.f */
+incdir+common
common/glb_pkg.sv
src/glb_cfg_regs.sv
glb_bank/glb_bank.sv
glb_dma/glb_store_dma.sv
glb_dma/glb_load_dma.sv
src/glb_bank_switch.sv
src/glb_tile.sv
verification/tb_glb_tile.sv

/* Makefile */
TOP = tb_glb_tile

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -f list.f --top-module glb_tile

clean:
	rm -rf obj_dir
